// File: Makefile
# Verilator build and run for the sd card CMD0 probe

VERILATOR ?= verilator
TOP       ?= tb_sd_cmd0_probe
FILELIST  ?= sd_cmd0_probe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: probe_pkg.sv
// board-level report types
`default_nettype none

package probe_pkg;

    // one ascii character on the serial line
    typedef logic [7:0] char_t;

    // sent once the power-up wait is over
    localparam char_t CHAR_START = 8'h53;

    // leads the result line
    localparam char_t CHAR_DONE = 8'h44;

    // between D and the hex digits
    localparam char_t CHAR_SPACE = 8'h20;

    // power-up wait counter
    // 32 bits covers seconds at 50 MHz
    typedef logic [31:0] cycle_count_t;

endpackage

`default_nettype wire

// File: result_reporter.sv
// report line builder, S then D + hex
`timescale 1ns/10ps
`default_nettype none

module result_reporter (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   powered_up,
    input  logic                   result_valid,
    input  sd_proto_pkg::sd_byte_t result_byte,
    input  logic                   tx_done,
    output logic                   tx_start,
    output probe_pkg::char_t       tx_char
);

    // next character of the result line
    typedef enum logic [1:0] {
        msg_idle,
        msg_space,
        msg_high,
        msg_low
    } msg_t;

    msg_t                   msg;
    logic                   tx_busy;
    logic                   pend_start;
    logic                   pend_result;
    sd_proto_pkg::sd_byte_t result_q;
    logic                   line_free;
    logic                   want_start;
    logic                   want_result;

    // nibble to 0-9 / A-F
    function automatic probe_pkg::char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return probe_pkg::char_t'(8'h30 + {4'h0, nib});
        end
        // 'A' minus 10
        return probe_pkg::char_t'(8'h37 + {4'h0, nib});
    endfunction

    // next char may go out in the done cycle
    assign line_free   = !tx_busy || tx_done;
    // fresh requests are served in their own cycle
    assign want_start  = pend_start || powered_up;
    assign want_result = pend_result || result_valid;

    always_ff @(posedge CLOCK_50) begin
        if (result_valid) begin
            result_q <= result_byte;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            msg         <= msg_idle;
            tx_busy     <= 1'b0;
            pend_start  <= 1'b0;
            pend_result <= 1'b0;
            tx_start    <= 1'b0;
            tx_char     <= '0;
        end else begin
            tx_start <= 1'b0;
            if (powered_up) begin
                pend_start <= 1'b1;
            end
            if (result_valid) begin
                pend_result <= 1'b1;
            end
            if (tx_done) begin
                tx_busy <= 1'b0;
            end
            if (line_free) begin
                if (want_start) begin
                    tx_char    <= probe_pkg::CHAR_START;
                    tx_start   <= 1'b1;
                    tx_busy    <= 1'b1;
                    pend_start <= 1'b0;
                end else if (msg != msg_idle) begin
                    tx_start <= 1'b1;
                    tx_busy  <= 1'b1;
                    case (msg)
                        msg_space: begin
                            tx_char <= probe_pkg::CHAR_SPACE;
                            msg     <= msg_high;
                        end
                        msg_high: begin
                            tx_char <= hex_char(result_q[7:4]);
                            msg     <= msg_low;
                        end
                        default: begin
                            tx_char <= hex_char(result_q[3:0]);
                            msg     <= msg_idle;
                        end
                    endcase
                end else if (want_result) begin
                    // result byte is latched by the time the digits go
                    tx_char     <= probe_pkg::CHAR_DONE;
                    tx_start    <= 1'b1;
                    tx_busy     <= 1'b1;
                    pend_result <= 1'b0;
                    msg         <= msg_space;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sd_card_model.sv
// spi-mode sd card model for the testbench
`timescale 1ns/10ps
`default_nettype none

module sd_card_model (
    input  logic                   CLOCK_50,
    input  logic                   clear,
    input  logic                   spi_sclk,
    input  logic                   spi_mosi,
    input  logic                   spi_ss_n,
    input  logic                   answer_en,
    input  logic [7:0]             answer_after,
    input  sd_proto_pkg::sd_byte_t answer_byte,
    output logic                   spi_miso,
    output logic [15:0]            sel_bytes,
    output logic [15:0]            desel_clocks,
    output logic [15:0]            desel_mosi_low
);

    // bytes seen while selected, in order
    sd_proto_pkg::sd_byte_t rx_log [0:511];
    logic                   sclk_q;
    logic [2:0]             bit_cnt;
    sd_proto_pkg::sd_byte_t in_shift;
    sd_proto_pkg::sd_byte_t out_shift;
    sd_proto_pkg::sd_byte_t next_out;

    // released line reads high
    assign spi_miso = spi_ss_n ? 1'b1 : out_shift[7];

    // sampled on the falling system clock, where the dut pins are settled
    always @(negedge CLOCK_50) begin
        if (clear) begin
            sclk_q         <= 1'b0;
            bit_cnt        <= '0;
            in_shift       <= '0;
            out_shift      <= 8'hFF;
            next_out       <= 8'hFF;
            sel_bytes      <= '0;
            desel_clocks   <= '0;
            desel_mosi_low <= '0;
        end else begin
            sclk_q <= spi_sclk;
            // rising sclk
            if (spi_sclk && !sclk_q) begin
                if (spi_ss_n) begin
                    desel_clocks <= desel_clocks + 16'd1;
                    if (!spi_mosi) begin
                        desel_mosi_low <= desel_mosi_low + 16'd1;
                    end
                end else begin
                    in_shift <= {in_shift[6:0], spi_mosi};
                    bit_cnt  <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        rx_log[sel_bytes[8:0]] <= {in_shift[6:0], spi_mosi};
                        sel_bytes              <= sel_bytes + 16'd1;
                        // answer goes in poll byte answer_after + 1
                        if (answer_en && (sel_bytes + 16'd1 ==
                            16'(sd_proto_pkg::SD_CMD_LEN) + 16'(answer_after))) begin
                            next_out <= answer_byte;
                        end else begin
                            next_out <= 8'hFF;
                        end
                    end
                end
            end
            // falling sclk, next miso bit
            if (!spi_sclk && sclk_q && !spi_ss_n) begin
                if (bit_cnt == 3'd0) begin
                    out_shift <= next_out;
                end else begin
                    out_shift <= {out_shift[6:0], 1'b1};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sd_cmd0_probe.f
sd_proto_pkg.sv
probe_pkg.sv
spi_byte_master.sv
sd_init_sequencer.sv
result_reporter.sv
uart_tx.sv
sd_cmd0_probe.sv
sd_card_model.sv
tb_sd_cmd0_probe.sv

// File: sd_cmd0_probe.sv
// sd card CMD0 probe, board top
`timescale 1ns/10ps
`default_nettype none

module sd_cmd0_probe #(
    parameter int POWER_UP_CYCLES = 2_000_000,
    parameter int SCLK_HALF       = 4,
    parameter int BAUD_DIV        = 434
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic spi_miso,
    output logic spi_sclk,
    output logic spi_mosi,
    output logic spi_ss_n,
    output logic uart_txd,
    output logic ledr0
);

    logic                   spi_start;
    logic                   spi_done;
    sd_proto_pkg::sd_byte_t spi_tx_byte;
    sd_proto_pkg::sd_byte_t spi_rx_byte;
    logic                   card_select;
    logic                   powered_up;
    logic                   result_valid;
    sd_proto_pkg::sd_byte_t result_byte;
    logic                   tx_start;
    logic                   tx_done;
    probe_pkg::char_t       tx_char;

    // cs is active low on the card
    assign spi_ss_n = ~card_select;
    // led lit while the card is selected
    assign ledr0    = card_select;

    sd_init_sequencer #(
        .POWER_UP_CYCLES(POWER_UP_CYCLES)
    ) sd_init_sequencer_inst (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .spi_done    (spi_done),
        .spi_rx_byte (spi_rx_byte),
        .spi_start   (spi_start),
        .spi_tx_byte (spi_tx_byte),
        .card_select (card_select),
        .powered_up  (powered_up),
        .result_valid(result_valid),
        .result_byte (result_byte)
    );

    spi_byte_master #(
        .SCLK_HALF(SCLK_HALF)
    ) spi_byte_master_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .spi_start  (spi_start),
        .spi_tx_byte(spi_tx_byte),
        .spi_miso   (spi_miso),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_done   (spi_done),
        .spi_rx_byte(spi_rx_byte)
    );

    result_reporter result_reporter_inst (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .powered_up  (powered_up),
        .result_valid(result_valid),
        .result_byte (result_byte),
        .tx_done     (tx_done),
        .tx_start    (tx_start),
        .tx_char     (tx_char)
    );

    uart_tx #(
        .BAUD_DIV(BAUD_DIV)
    ) uart_tx_inst (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .tx_start(tx_start),
        .tx_char (tx_char),
        .uart_txd(uart_txd),
        .tx_done (tx_done)
    );

endmodule

`default_nettype wire

// File: sd_init_sequencer.sv
// sd card spi-mode bring-up
// power-up wait, wake-up clocks, CMD0, response poll
`timescale 1ns/10ps
`default_nettype none

module sd_init_sequencer #(
    parameter int POWER_UP_CYCLES = 2_000_000
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   spi_done,
    input  sd_proto_pkg::sd_byte_t spi_rx_byte,
    output logic                   spi_start,
    output sd_proto_pkg::sd_byte_t spi_tx_byte,
    output logic                   card_select,
    output logic                   powered_up,
    output logic                   result_valid,
    output sd_proto_pkg::sd_byte_t result_byte
);

    typedef enum logic [2:0] {
        wait_power,
        dummy,
        select,
        command,
        poll,
        finish,
        stop
    } state_t;

    state_t                  state;
    probe_pkg::cycle_count_t wait_cnt;
    // bytes done in the current phase
    logic [7:0]              byte_cnt;
    logic [2:0]              next_idx;
    logic                    poll_end;

    // next CMD0 byte
    assign next_idx = byte_cnt[2:0] + 3'd1;

    // card answered or stayed silent too long
    assign poll_end = (spi_rx_byte != sd_proto_pkg::SD_IDLE_BYTE) ||
                      (byte_cnt == 8'(sd_proto_pkg::SD_NCR_LIMIT - 1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state        <= wait_power;
            wait_cnt     <= '0;
            byte_cnt     <= '0;
            spi_start    <= 1'b0;
            spi_tx_byte  <= sd_proto_pkg::SD_IDLE_BYTE;
            card_select  <= 1'b0;
            powered_up   <= 1'b0;
            result_valid <= 1'b0;
            result_byte  <= sd_proto_pkg::SD_IDLE_BYTE;
        end else begin
            // strobes last one cycle
            spi_start    <= 1'b0;
            powered_up   <= 1'b0;
            result_valid <= 1'b0;

            case (state)
                wait_power: begin
                    wait_cnt <= wait_cnt + probe_pkg::cycle_count_t'(1);
                    // announce first so S starts ahead of any sclk edge
                    if (wait_cnt == probe_pkg::cycle_count_t'(POWER_UP_CYCLES - 1)) begin
                        powered_up <= 1'b1;
                    end
                    if (wait_cnt == probe_pkg::cycle_count_t'(POWER_UP_CYCLES)) begin
                        spi_start   <= 1'b1;
                        spi_tx_byte <= sd_proto_pkg::SD_IDLE_BYTE;
                        byte_cnt    <= '0;
                        state       <= dummy;
                    end
                end

                // 0xFF bytes with the card deselected give the wake-up clocks
                dummy: begin
                    if (spi_done) begin
                        if (byte_cnt == 8'(sd_proto_pkg::SD_DUMMY_BYTES - 1)) begin
                            card_select <= 1'b1;
                            state       <= select;
                        end else begin
                            byte_cnt    <= byte_cnt + 8'd1;
                            spi_start   <= 1'b1;
                            spi_tx_byte <= sd_proto_pkg::SD_IDLE_BYTE;
                        end
                    end
                end

                // cs is low one cycle before the frame starts
                select: begin
                    byte_cnt    <= '0;
                    spi_start   <= 1'b1;
                    spi_tx_byte <= sd_proto_pkg::SD_CMD0[0];
                    state       <= command;
                end

                command: begin
                    if (spi_done) begin
                        spi_start <= 1'b1;
                        if (byte_cnt == 8'(sd_proto_pkg::SD_CMD_LEN - 1)) begin
                            // fillers after the crc clock out the r1 answer
                            byte_cnt    <= '0;
                            spi_tx_byte <= sd_proto_pkg::SD_IDLE_BYTE;
                            state       <= poll;
                        end else begin
                            byte_cnt    <= byte_cnt + 8'd1;
                            spi_tx_byte <= sd_proto_pkg::SD_CMD0[next_idx];
                        end
                    end
                end

                poll: begin
                    if (spi_done) begin
                        if (poll_end) begin
                            // 0xFF here means timeout
                            result_byte <= spi_rx_byte;
                            state       <= finish;
                        end else begin
                            byte_cnt    <= byte_cnt + 8'd1;
                            spi_start   <= 1'b1;
                            spi_tx_byte <= sd_proto_pkg::SD_IDLE_BYTE;
                        end
                    end
                end

                finish: begin
                    card_select  <= 1'b0;
                    result_valid <= 1'b1;
                    state        <= stop;
                end

                // one run per reset
                default: begin
                    state <= stop;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sd_proto_pkg.sv
// sd card spi-mode protocol
// wire bytes, command frame, poll limit
`default_nettype none

package sd_proto_pkg;

    // one byte on the spi wire
    typedef logic [7:0] sd_byte_t;

    // mosi filler between frames
    // a card with nothing to say also returns this
    localparam sd_byte_t SD_IDLE_BYTE = 8'hFF;

    // sent with the card deselected, 8 clocks each
    localparam int SD_DUMMY_BYTES = 10;

    // command frame: index, 4 argument bytes, crc
    localparam int SD_CMD_LEN = 6;

    // go_idle_state with zero argument
    // the card still checks crc before spi mode is entered, so 0x95 must be right
    localparam sd_byte_t SD_CMD0 [SD_CMD_LEN] = '{
        8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95
    };

    // max ncr poll bytes after the frame
    localparam int SD_NCR_LIMIT = 255;

endpackage

`default_nettype wire

// File: spi_byte_master.sv
// spi mode 0 byte master
`timescale 1ns/10ps
`default_nettype none

module spi_byte_master #(
    // CLOCK_50 cycles per sclk half period, 2 or more
    parameter int SCLK_HALF = 4
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   spi_start,
    input  sd_proto_pkg::sd_byte_t spi_tx_byte,
    input  logic                   spi_miso,
    output logic                   spi_sclk,
    output logic                   spi_mosi,
    output logic                   spi_done,
    output sd_proto_pkg::sd_byte_t spi_rx_byte
);

    localparam int DIV_W = $clog2(SCLK_HALF);

    logic                   busy;
    logic [DIV_W-1:0]       div_cnt;
    logic [3:0]             edge_cnt;
    sd_proto_pkg::sd_byte_t tx_shift;
    sd_proto_pkg::sd_byte_t rx_shift;
    logic                   half_end;
    logic                   rise_edge;
    logic                   fall_edge;
    logic                   last_edge;

    // sclk toggles at the end of each half period
    assign half_end  = busy && (div_cnt == DIV_W'(SCLK_HALF - 1));
    assign rise_edge = half_end && !spi_sclk;
    assign fall_edge = half_end && spi_sclk;
    // 16th edge, always a falling one
    assign last_edge = fall_edge && (edge_cnt == 4'd15);

    // msb first, line rests high between bytes
    assign spi_mosi = busy ? tx_shift[7] : 1'b1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            spi_sclk <= 1'b0;
            spi_done <= 1'b0;
        end else begin
            spi_done <= last_edge;
            if (!busy) begin
                if (spi_start) begin
                    busy     <= 1'b1;
                    // start cycle counts toward the first half period
                    div_cnt  <= DIV_W'(1);
                    edge_cnt <= '0;
                end
            end else if (half_end) begin
                div_cnt  <= '0;
                spi_sclk <= ~spi_sclk;
                edge_cnt <= edge_cnt + 4'd1;
                if (edge_cnt == 4'd15) begin
                    busy <= 1'b0;
                end
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

    // data path
    always_ff @(posedge CLOCK_50) begin
        // first bit is on mosi right after start
        if (spi_start && !busy) begin
            tx_shift <= spi_tx_byte;
        end else if (fall_edge) begin
            tx_shift <= {tx_shift[6:0], 1'b1};
        end
        // sample on rising sclk
        if (rise_edge) begin
            rx_shift <= {rx_shift[6:0], spi_miso};
        end
        // held until the next byte ends
        if (last_edge) begin
            spi_rx_byte <= rx_shift;
        end
    end

endmodule

`default_nettype wire

// File: tb_sd_cmd0_probe.sv
// sd card CMD0 probe testbench
`timescale 1ns/10ps
`default_nettype none

module tb_sd_cmd0_probe;

    localparam int POWER_UP_CYCLES = 50;
    localparam int SCLK_HALF       = 2;
    localparam int BAUD_DIV        = 8;
    // upper bounds per byte and per character, gaps included
    localparam int BYTE_CYCLES = 16 * SCLK_HALF + 4;
    localparam int CHAR_CYCLES = 10 * BAUD_DIV + 2;
    // silent card, every poll byte used
    localparam int SEQ_CYCLES = 16 + POWER_UP_CYCLES + 100 + 5 * CHAR_CYCLES +
        (sd_proto_pkg::SD_DUMMY_BYTES + sd_proto_pkg::SD_CMD_LEN +
         sd_proto_pkg::SD_NCR_LIMIT + 1) * BYTE_CYCLES;
    localparam int TIMEOUT_CYCLES = 5 * SEQ_CYCLES;
    // go_idle_state frame, first byte in the top bits
    localparam logic [47:0] CMD0_FRAME = 48'h40_0000_0000_95;

    logic                   CLOCK_50;
    logic                   KEY0;
    logic                   spi_miso;
    logic                   spi_sclk;
    logic                   spi_mosi;
    logic                   spi_ss_n;
    logic                   uart_txd;
    logic                   ledr0;
    logic                   card_clear;
    logic                   answer_en;
    logic [7:0]             answer_after;
    sd_proto_pkg::sd_byte_t answer_byte;
    logic [15:0]            sel_bytes;
    logic [15:0]            desel_clocks;
    logic [15:0]            desel_mosi_low;

    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    int                     cycle_count;
    logic                   sclk_prev;
    int                     sclk_rises;
    int                     ledr_bad;
    int                     sclk_at_start;
    int                     bit_idx;
    probe_pkg::char_t       rx_char;
    probe_pkg::char_t       rx_chars [$];

    sd_cmd0_probe #(
        .POWER_UP_CYCLES(POWER_UP_CYCLES),
        .SCLK_HALF      (SCLK_HALF),
        .BAUD_DIV       (BAUD_DIV)
    ) sd_cmd0_probe_inst (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .spi_miso(spi_miso),
        .spi_sclk(spi_sclk),
        .spi_mosi(spi_mosi),
        .spi_ss_n(spi_ss_n),
        .uart_txd(uart_txd),
        .ledr0   (ledr0)
    );

    sd_card_model card (
        .CLOCK_50      (CLOCK_50),
        .clear         (card_clear),
        .spi_sclk      (spi_sclk),
        .spi_mosi      (spi_mosi),
        .spi_ss_n      (spi_ss_n),
        .answer_en     (answer_en),
        .answer_after  (answer_after),
        .answer_byte   (answer_byte),
        .spi_miso      (spi_miso),
        .sel_bytes     (sel_bytes),
        .desel_clocks  (desel_clocks),
        .desel_mosi_low(desel_mosi_low)
    );

    // 100 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #50 CLOCK_50 = ~CLOCK_50;
        end
    end

    // sclk edge counter, ledr0 seen on every selected edge
    always @(negedge CLOCK_50) begin
        if (!KEY0) begin
            sclk_prev  <= 1'b0;
            sclk_rises <= 0;
            ledr_bad   <= 0;
        end else begin
            sclk_prev <= spi_sclk;
            if (spi_sclk && !sclk_prev) begin
                sclk_rises <= sclk_rises + 1;
                if (!spi_ss_n && !ledr0) begin
                    ledr_bad <= ledr_bad + 1;
                end
            end
        end
    end

    // uart receiver, sampling near the middle of each bit
    always begin
        @(negedge CLOCK_50);
        if (KEY0 && !uart_txd) begin
            if (rx_chars.size() == 0) begin
                sclk_at_start = sclk_rises;
            end
            repeat (BAUD_DIV / 2) @(negedge CLOCK_50);
            assert (!uart_txd) else begin
                $display("uart start bit did not hold low");
                errors = errors + 1;
            end
            // lsb first, shifted in from the top
            for (bit_idx = 0; bit_idx < 8; bit_idx = bit_idx + 1) begin
                repeat (BAUD_DIV) @(negedge CLOCK_50);
                rx_char = {uart_txd, rx_char[7:1]};
            end
            repeat (BAUD_DIV) @(negedge CLOCK_50);
            assert (uart_txd) else begin
                $display("uart stop bit was low (framing error)");
                errors = errors + 1;
            end
            rx_chars.push_back(rx_char);
        end
    end

    // hard stop for a hung run
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLOCK_50);
            cycle_count = cycle_count + 1;
        end
        $display("timeout after %0d cycles, the report never completed", cycle_count);
        $display("Regression failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        if (errors > err_before) begin
            tests_failed = tests_failed + 1;
            $display("test %-14s FAILED (%0d errors)", name, errors - err_before);
        end else begin
            $display("test %-14s ok", name);
        end
    endtask

    // KEY0 low for 16 cycles, card configured
    task automatic hold_reset(input logic en, input logic [7:0] after,
                              input sd_proto_pkg::sd_byte_t resp);
        @(negedge CLOCK_50);
        KEY0          = 1'b0;
        card_clear    = 1'b1;
        answer_en     = en;
        answer_after  = after;
        answer_byte   = resp;
        sclk_at_start = -1;
        rx_chars.delete();
        repeat (16) @(negedge CLOCK_50);
    endtask

    task automatic release_reset();
        card_clear = 1'b0;
        KEY0       = 1'b1;
    endtask

    // whole bring-up until the report is out and the line is quiet
    task automatic run_sequence(input logic en, input logic [7:0] after,
                                input sd_proto_pkg::sd_byte_t resp);
        hold_reset(en, after, resp);
        release_reset();
        while (rx_chars.size() < 5) begin
            @(negedge CLOCK_50);
        end
        repeat (2 * CHAR_CYCLES) @(negedge CLOCK_50);
        assert (rx_chars.size() == 5) else begin
            $display("expected 5 report characters, received %0d", rx_chars.size());
            errors = errors + 1;
        end
    endtask

    task automatic check_report(input string exp);
        for (int i = 0; i < exp.len() && i < rx_chars.size(); i++) begin
            check_value($sformatf("uart char %0d", i), 32'(rx_chars[i]), 32'(exp[i]));
        end
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        hold_reset(1'b1, 8'd3, 8'h01);
        check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
        check_value("spi_sclk", 32'(spi_sclk), 32'd0);
        check_value("spi_mosi", 32'(spi_mosi), 32'd1);
        check_value("uart_txd", 32'(uart_txd), 32'd1);
        check_value("ledr0", 32'(ledr0), 32'd0);
        release_reset();
        // still inside the power-up wait
        repeat (POWER_UP_CYCLES / 2) @(negedge CLOCK_50);
        check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
        check_value("spi_sclk", 32'(spi_sclk), 32'd0);
        check_value("uart_txd", 32'(uart_txd), 32'd1);
        check_value("ledr0", 32'(ledr0), 32'd0);
        finish_test("reset state", err0);
    endtask

    task automatic test_start_char();
        int err0;
        err0 = errors;
        run_sequence(1'b1, 8'd3, 8'h01);
        check_value("uart char 0", 32'(rx_chars[0]), 32'h53);
        check_value("sclk edges before S", 32'(sclk_at_start), 32'd0);
        finish_test("start char", err0);
    endtask

    task automatic test_dummy_clocks();
        int err0;
        err0 = errors;
        run_sequence(1'b1, 8'd3, 8'h01);
        check_value("deselected sclk rises", 32'(desel_clocks), 32'd80);
        check_value("deselected mosi low", 32'(desel_mosi_low), 32'd0);
        finish_test("dummy clocks", err0);
    endtask

    task automatic test_cmd0_frame();
        int err0;
        err0 = errors;
        run_sequence(1'b1, 8'd3, 8'h01);
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("mosi byte %0d", i), 32'(card.rx_log[9'(i)]),
                        32'(8'(CMD0_FRAME >> (8 * (5 - i)))));
        end
        assert (ledr_bad == 0) else begin
            $display("ledr0 was off on %0d selected sclk edges", ledr_bad);
            errors = errors + 1;
        end
        finish_test("cmd0 frame", err0);
    endtask

    task automatic test_answer();
        int err0;
        err0 = errors;
        run_sequence(1'b1, 8'd3, 8'h01);
        check_report("SD 01");
        check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
        // three silent bytes plus the answer
        check_value("poll bytes", 32'(sel_bytes) - 32'd6, 32'd4);
        finish_test("answer 01", err0);
    endtask

    task automatic test_no_answer();
        int err0;
        err0 = errors;
        run_sequence(1'b0, 8'd0, 8'hFF);
        check_report("SD FF");
        check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
        check_value("poll bytes", 32'(sel_bytes) - 32'd6, 32'd255);
        finish_test("no answer", err0);
    endtask

    initial begin
        KEY0          = 1'b0;
        card_clear    = 1'b1;
        answer_en     = 1'b0;
        answer_after  = 8'd0;
        answer_byte   = 8'hFF;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        sclk_at_start = -1;
        test_reset_state();
        test_start_char();
        test_dummy_clocks();
        test_cmd0_frame();
        test_answer();
        test_no_answer();
        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 serial transmitter
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    // CLOCK_50 cycles per bit
    parameter int BAUD_DIV = 434
) (
    input  logic             CLOCK_50,
    input  logic             KEY0,
    input  logic             tx_start,
    input  probe_pkg::char_t tx_char,
    output logic             uart_txd,
    output logic             tx_done
);

    localparam int BAUD_W = $clog2(BAUD_DIV);

    logic              busy;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    // stop, data lsb first, start
    logic [9:0]        frame;
    logic              bit_end;

    assign bit_end  = busy && (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    // last cycle of the stop bit
    assign tx_done  = bit_end && (bit_cnt == 4'd9);
    // idle high
    assign uart_txd = busy ? frame[0] : 1'b1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end
        end else begin
            baud_cnt <= baud_cnt + BAUD_W'(1);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (tx_start && !busy) begin
            frame <= {1'b1, tx_char, 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

`default_nettype wire
